/* smartnic_pkg.sv */
package smartnic_pkg;

    // --------------------------------------------------
    // Stream beat
    // --------------------------------------------------

    // Datapath width is fixed here since the beat struct depends on it
    localparam int AXIS_DATA_BYTE_WID = 8;
    localparam int AXIS_DATA_WID      = AXIS_DATA_BYTE_WID * 8;
    localparam int PID_WID            = 16;

    typedef logic [3:0] port_t;

    typedef struct packed {
        logic [AXIS_DATA_WID-1:0]      tdata;
        logic [AXIS_DATA_BYTE_WID-1:0] tkeep;
        logic                          tlast;
        port_t                         tid;
        port_t                         tdest;
        logic [PID_WID-1:0]            pid;
    } axis_beat_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------

    localparam int REG_DATA_WID = 32;

    // Field order puts enable at bit 0 and value at bit 1
    typedef struct packed {
        logic value;
        logic enable;
    } demux_ctrl_t;

    typedef enum logic [7:0] {
        REG_DEMUX_CTRL = 8'h00,
        REG_STATUS     = 8'h04
    } reg_addr_t;

    // Read data for any address outside the map
    localparam logic [REG_DATA_WID-1:0] REG_BAD_DATA = 32'hDEADBEEF;

endpackage : smartnic_pkg

/* app_regs.sv */
`timescale 1ns/1ps

module app_regs #(
    parameter int NUM_PORTS = 2
) (
    input  logic                     core_clk,
    input  logic                     rst,

    // Register access strobes
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  smartnic_pkg::reg_addr_t  reg_addr,
    input  logic [31:0]              reg_wdata,
    output logic [31:0]              reg_rdata,
    output logic                     reg_rvalid,

    // Datapath side
    input  logic [NUM_PORTS-1:0]     pkt_active,
    output smartnic_pkg::demux_ctrl_t demux_ctrl
);
    import smartnic_pkg::*;

    logic igr_busy;

    // Any port in the middle of an ingress packet
    assign igr_busy = |pkt_active;

    // Override register, visible to the demuxes one cycle after the write
    always_ff @(posedge core_clk) begin
        if (rst) begin
            demux_ctrl <= '0;
        end else if (reg_wr && reg_addr == REG_DEMUX_CTRL) begin
            demux_ctrl <= demux_ctrl_t'(reg_wdata[1:0]);
        end
    end

    // Read response valid for exactly one cycle
    always_ff @(posedge core_clk) begin
        if (rst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_DEMUX_CTRL: reg_rdata <= {30'b0, demux_ctrl};
                REG_STATUS:     reg_rdata <= {31'b0, igr_busy};
                default:        reg_rdata <= REG_BAD_DATA;
            endcase
        end
    end

endmodule : app_regs

/* axis_demux.sv */
`timescale 1ns/1ps

module axis_demux (
    input  logic                      core_clk,
    input  logic                      rst,

    input  smartnic_pkg::demux_ctrl_t demux_ctrl,

    // Upstream
    input  logic                      in_valid,
    output logic                      in_ready,
    input  smartnic_pkg::axis_beat_t  in_beat,

    // Two downstream outputs sharing one beat bus
    output logic [1:0]                out_valid,
    input  logic [1:0]                out_ready,
    output smartnic_pkg::axis_beat_t  out_beat,

    output logic                      pkt_active
);

    logic in_pkt;
    logic sel_q;
    logic sel;
    logic xfer;

    // --------------------------------------------------
    // Output selection
    // --------------------------------------------------

    // Fresh decision on a first beat, held choice for the rest of the packet
    always_comb begin
        if (in_pkt) begin
            sel = sel_q;
        end else if (demux_ctrl.enable) begin
            sel = demux_ctrl.value;
        end else begin
            sel = in_beat.tdest[0];
        end
    end

    assign out_valid[0] = in_valid && (sel == 1'b0);
    assign out_valid[1] = in_valid && (sel == 1'b1);
    assign out_beat     = in_beat;
    assign in_ready     = out_ready[sel];

    assign xfer = in_valid && in_ready;

    // --------------------------------------------------
    // Packet tracking
    // --------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
            sel_q  <= 1'b0;
        end else if (xfer) begin
            if (in_beat.tlast) begin
                in_pkt <= 1'b0;
            end else begin
                in_pkt <= 1'b1;
                sel_q  <= sel;
            end
        end
    end

    assign pkt_active = in_pkt;

endmodule : axis_demux

/* axis_pipe.sv */
`timescale 1ns/1ps

module axis_pipe (
    input  logic                     core_clk,
    input  logic                     rst,

    input  logic                     in_valid,
    output logic                     in_ready,
    input  smartnic_pkg::axis_beat_t in_beat,

    output logic                     out_valid,
    input  logic                     out_ready,
    output smartnic_pkg::axis_beat_t out_beat
);
    import smartnic_pkg::*;

    // Second entry catches a beat while the output is stalled
    logic       skid_valid;
    axis_beat_t skid_beat;
    logic       out_load;

    // Room for another beat as long as the skid entry is free
    assign in_ready = !skid_valid;

    // Output register may take a new beat this cycle
    assign out_load = out_ready || !out_valid;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid  <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Beat payload, no reset needed
    always_ff @(posedge core_clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_beat <= skid_beat;
            end else if (in_valid) begin
                out_beat <= in_beat;
            end
        end else if (in_valid && in_ready) begin
            skid_beat <= in_beat;
        end
    end

endmodule : axis_pipe

/* axis_mux.sv */
`timescale 1ns/1ps

module axis_mux (
    input  logic                     core_clk,
    input  logic                     rst,

    input  logic [1:0]               in_valid,
    output logic [1:0]               in_ready,
    input  smartnic_pkg::axis_beat_t in_beat [2],

    output logic                     out_valid,
    input  logic                     out_ready,
    output smartnic_pkg::axis_beat_t out_beat
);

    typedef enum logic {
        ARB_IDLE,
        ARB_PKT
    } arb_state_t;

    arb_state_t state;
    // Round-robin pointer, the input preferred at the next packet boundary
    logic       grant;
    // Input that owns the output from its first offered beat to its tlast
    logic       owner;
    logic       sel;
    logic       xfer;

    // --------------------------------------------------
    // Input selection
    // --------------------------------------------------
    always_comb begin
        if (state == ARB_PKT) begin
            sel = owner;
        end else if (in_valid[grant]) begin
            sel = grant;
        end else if (in_valid[!grant]) begin
            sel = !grant;
        end else begin
            sel = grant;
        end
    end

    assign out_valid   = in_valid[sel];
    assign out_beat    = in_beat[sel];
    assign in_ready[0] = out_ready && (sel == 1'b0);
    assign in_ready[1] = out_ready && (sel == 1'b1);

    assign xfer = out_valid && out_ready;

    // --------------------------------------------------
    // Arbitration FSM
    // --------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= 1'b0;
            owner <= 1'b0;
        end else if (xfer && out_beat.tlast) begin
            // Packet done, the other input goes first next time
            state <= ARB_IDLE;
            grant <= !sel;
        end else if (state == ARB_IDLE && out_valid) begin
            // An offered beat locks its input, even while stalled
            state <= ARB_PKT;
            owner <= sel;
        end
    end

endmodule : axis_mux

/* smartnic_app.sv */
`timescale 1ns/1ps

module smartnic_app #(
    parameter int NUM_PORTS = 2
) (
    input  logic                       core_clk,
    input  logic                       rst,

    // Ingress from the packet ports
    input  logic [NUM_PORTS-1:0]       axis_app_igr_tvalid,
    output logic [NUM_PORTS-1:0]       axis_app_igr_tready,
    input  smartnic_pkg::axis_beat_t   axis_app_igr_beat [NUM_PORTS],

    // Egress to the packet ports
    output logic [NUM_PORTS-1:0]       axis_app_egr_tvalid,
    input  logic [NUM_PORTS-1:0]       axis_app_egr_tready,
    output smartnic_pkg::axis_beat_t   axis_app_egr_beat [NUM_PORTS],

    // Card to host
    output logic [NUM_PORTS-1:0]       axis_c2h_tvalid,
    input  logic [NUM_PORTS-1:0]       axis_c2h_tready,
    output smartnic_pkg::axis_beat_t   axis_c2h_beat [NUM_PORTS],

    // Host to card
    input  logic [NUM_PORTS-1:0]       axis_h2c_tvalid,
    output logic [NUM_PORTS-1:0]       axis_h2c_tready,
    input  smartnic_pkg::axis_beat_t   axis_h2c_beat [NUM_PORTS],

    // Register port
    input  logic                       reg_wr,
    input  logic                       reg_rd,
    input  smartnic_pkg::reg_addr_t    reg_addr,
    input  logic [31:0]                reg_wdata,
    output logic [31:0]                reg_rdata,
    output logic                       reg_rvalid
);
    import smartnic_pkg::*;

    demux_ctrl_t          demux_ctrl;
    logic [NUM_PORTS-1:0] igr_pkt_active;

    // --------------------------------------------------
    // Register block
    // --------------------------------------------------
    app_regs #(
        .NUM_PORTS (NUM_PORTS)
    ) u_app_regs (
        .core_clk   (core_clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .pkt_active (igr_pkt_active),
        .demux_ctrl (demux_ctrl)
    );

    // --------------------------------------------------
    // Per-port datapath
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g__port
        logic [1:0] demux_out_valid;
        logic [1:0] demux_out_ready;
        axis_beat_t demux_out_beat;

        // Application loop-back path
        logic       app_valid;
        logic       app_ready;
        axis_beat_t app_beat;

        logic [1:0] mux_in_valid;
        logic [1:0] mux_in_ready;
        axis_beat_t mux_in_beat [2];

        axis_demux u_demux (
            .core_clk   (core_clk),
            .rst        (rst),
            .demux_ctrl (demux_ctrl),
            .in_valid   (axis_app_igr_tvalid[i]),
            .in_ready   (axis_app_igr_tready[i]),
            .in_beat    (axis_app_igr_beat[i]),
            .out_valid  (demux_out_valid),
            .out_ready  (demux_out_ready),
            .out_beat   (demux_out_beat),
            .pkt_active (igr_pkt_active[i])
        );

        axis_pipe u_pipe_app (
            .core_clk  (core_clk),
            .rst       (rst),
            .in_valid  (demux_out_valid[0]),
            .in_ready  (demux_out_ready[0]),
            .in_beat   (demux_out_beat),
            .out_valid (app_valid),
            .out_ready (app_ready),
            .out_beat  (app_beat)
        );

        axis_pipe u_pipe_c2h (
            .core_clk  (core_clk),
            .rst       (rst),
            .in_valid  (demux_out_valid[1]),
            .in_ready  (demux_out_ready[1]),
            .in_beat   (demux_out_beat),
            .out_valid (axis_c2h_tvalid[i]),
            .out_ready (axis_c2h_tready[i]),
            .out_beat  (axis_c2h_beat[i])
        );

        // Mux input 0 is the loop-back, input 1 is h2c
        assign mux_in_valid       = {axis_h2c_tvalid[i], app_valid};
        assign mux_in_beat[0]     = app_beat;
        assign mux_in_beat[1]     = axis_h2c_beat[i];
        assign app_ready          = mux_in_ready[0];
        assign axis_h2c_tready[i] = mux_in_ready[1];

        axis_mux u_mux (
            .core_clk  (core_clk),
            .rst       (rst),
            .in_valid  (mux_in_valid),
            .in_ready  (mux_in_ready),
            .in_beat   (mux_in_beat),
            .out_valid (axis_app_egr_tvalid[i]),
            .out_ready (axis_app_egr_tready[i]),
            .out_beat  (axis_app_egr_beat[i])
        );
    end : g__port

endmodule : smartnic_app

/* tb_smartnic_app_chk.sv */
`timescale 1ns/1ps

module tb_smartnic_app_chk #(
    parameter int NUM_PORTS = 2
) (
    input logic                     core_clk,
    input logic                     rst,
    input logic [NUM_PORTS-1:0]     axis_c2h_tvalid,
    input logic [NUM_PORTS-1:0]     axis_c2h_tready,
    input smartnic_pkg::axis_beat_t axis_c2h_beat [NUM_PORTS],
    input logic [NUM_PORTS-1:0]     axis_app_egr_tvalid,
    input logic [NUM_PORTS-1:0]     axis_app_egr_tready,
    input smartnic_pkg::axis_beat_t axis_app_egr_beat [NUM_PORTS],
    input logic                     reg_rd,
    input logic                     reg_rvalid
);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g__port
        // Stalled c2h beat stays put until taken
        c2h_hold : assert property (@(posedge core_clk) disable iff (rst)
            axis_c2h_tvalid[i] && !axis_c2h_tready[i]
                |=> axis_c2h_tvalid[i] && $stable(axis_c2h_beat[i]))
            else $error("c2h port %0d changed or dropped a stalled beat", i);

        // Stalled egress beat stays put until taken
        egr_hold : assert property (@(posedge core_clk) disable iff (rst)
            axis_app_egr_tvalid[i] && !axis_app_egr_tready[i]
                |=> axis_app_egr_tvalid[i] && $stable(axis_app_egr_beat[i]))
            else $error("Egress port %0d changed or dropped a stalled beat", i);
    end : g__port

    rvalid_after_rd : assert property (@(posedge core_clk) disable iff (rst)
        reg_rvalid |-> $past(reg_rd))
        else $error("reg_rvalid without a read strobe on the cycle before");

    // Outputs quiet through reset
    quiet_in_reset : assert property (@(posedge core_clk)
        $past(rst) |-> !(|axis_c2h_tvalid) && !(|axis_app_egr_tvalid) && !reg_rvalid)
        else $error("Output valid high during reset");

endmodule : tb_smartnic_app_chk

bind smartnic_app tb_smartnic_app_chk #(
    .NUM_PORTS (NUM_PORTS)
) u_chk (
    .core_clk            (core_clk),
    .rst                 (rst),
    .axis_c2h_tvalid     (axis_c2h_tvalid),
    .axis_c2h_tready     (axis_c2h_tready),
    .axis_c2h_beat       (axis_c2h_beat),
    .axis_app_egr_tvalid (axis_app_egr_tvalid),
    .axis_app_egr_tready (axis_app_egr_tready),
    .axis_app_egr_beat   (axis_app_egr_beat),
    .reg_rd              (reg_rd),
    .reg_rvalid          (reg_rvalid)
);

/* tb_smartnic_app.sv */
`timescale 1ns/1ps

module tb_smartnic_app;
    import smartnic_pkg::*;

    localparam int NUM_PORTS       = 2;
    localparam int PKTS            = 24;
    localparam int MAX_LEN         = 6;
    // Three traffic phases, two sources per port
    localparam int TOTAL_BEATS     = 3 * 2 * NUM_PORTS * PKTS * MAX_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 1000;

    logic                 core_clk = 1'b0;
    logic                 rst;
    logic [NUM_PORTS-1:0] axis_app_igr_tvalid;
    logic [NUM_PORTS-1:0] axis_app_igr_tready;
    axis_beat_t           axis_app_igr_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] axis_app_egr_tvalid;
    logic [NUM_PORTS-1:0] axis_app_egr_tready;
    axis_beat_t           axis_app_egr_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] axis_c2h_tvalid;
    logic [NUM_PORTS-1:0] axis_c2h_tready;
    axis_beat_t           axis_c2h_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] axis_h2c_tvalid;
    logic [NUM_PORTS-1:0] axis_h2c_tready;
    axis_beat_t           axis_h2c_beat [NUM_PORTS];
    logic                 reg_wr;
    logic                 reg_rd;
    reg_addr_t            reg_addr;
    logic [31:0]          reg_wdata;
    logic [31:0]          reg_rdata;
    logic                 reg_rvalid;

    // Model queues, egress split by source (0 igr, 1 h2c)
    axis_beat_t  c2h_q [NUM_PORTS][$];
    axis_beat_t  egr_q [NUM_PORTS][2][$];
    demux_ctrl_t ovr;
    logic        igr_in_pkt [NUM_PORTS];
    logic        igr_dest [NUM_PORTS];
    logic        egr_in_pkt [NUM_PORTS];
    logic        egr_src [NUM_PORTS];
    logic        igr_done [NUM_PORTS];
    logic        h2c_done [NUM_PORTS];
    logic        rvalid_seen;
    logic [31:0] rdata_seen;

    // Packet generators, first index is the source
    int          pkts_sent [2][NUM_PORTS];
    int          beats_left [2][NUM_PORTS];
    int          seq [2][NUM_PORTS];
    port_t       cur_dest [2][NUM_PORTS];

    logic [31:0] rng_state;
    int          val_errs;
    int          other_errs;

    smartnic_app #(.NUM_PORTS(NUM_PORTS)) UUT (.*);

    always #50 core_clk = ~core_clk;

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic want_beat(input int src, input int p);
        if (beats_left[src][p] == 0 && pkts_sent[src][p] == PKTS) begin
            return 1'b0;
        end
        return (rand_next() % 4) != 0;
    endfunction

    // pid holds source, port and a running beat number
    function automatic axis_beat_t make_beat(input int src, input int p);
        axis_beat_t b;
        if (beats_left[src][p] == 0) begin
            beats_left[src][p] = 1 + int'(rand_next() % MAX_LEN);
            cur_dest[src][p]   = port_t'(rand_next());
            pkts_sent[src][p]++;
        end
        beats_left[src][p]--;
        b.tdata = {rand_next(), rand_next()};
        b.tlast = (beats_left[src][p] == 0);
        b.tkeep = b.tlast ? (8'hff >> (rand_next() % 8)) : 8'hff;
        b.tid   = port_t'(p);
        b.tdest = cur_dest[src][p];
        b.pid   = {src[0], p[2:0], seq[src][p][11:0]};
        seq[src][p]++;
        return b;
    endfunction

    task automatic drive_inputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!axis_app_igr_tvalid[p] || igr_done[p]) begin
                axis_app_igr_tvalid[p] = want_beat(0, p);
                if (axis_app_igr_tvalid[p]) begin
                    axis_app_igr_beat[p] = make_beat(0, p);
                end
            end
            if (!axis_h2c_tvalid[p] || h2c_done[p]) begin
                axis_h2c_tvalid[p] = want_beat(1, p);
                if (axis_h2c_tvalid[p]) begin
                    axis_h2c_beat[p] = make_beat(1, p);
                end
            end
            axis_c2h_tready[p]     = (rand_next() % 4) != 0;
            axis_app_egr_tready[p] = (rand_next() % 3) != 0;
        end
    endtask

    // --------------------------------------------------
    // Checks and model
    // --------------------------------------------------
    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            val_errs++;
        end
    endtask

    // Sampled mid-cycle, where every handshake is settled
    task automatic monitor();
        logic src;
        for (int p = 0; p < NUM_PORTS; p++) begin
            igr_done[p] = axis_app_igr_tvalid[p] && axis_app_igr_tready[p];
            h2c_done[p] = axis_h2c_tvalid[p] && axis_h2c_tready[p];
            if (igr_done[p]) begin
                if (!igr_in_pkt[p]) begin
                    igr_dest[p] = ovr.enable ? ovr.value : axis_app_igr_beat[p].tdest[0];
                end
                igr_in_pkt[p] = !axis_app_igr_beat[p].tlast;
                if (igr_dest[p]) begin
                    c2h_q[p].push_back(axis_app_igr_beat[p]);
                end else begin
                    egr_q[p][0].push_back(axis_app_igr_beat[p]);
                end
            end
            // h2c can reach egress in the same cycle
            if (h2c_done[p]) begin
                egr_q[p][1].push_back(axis_h2c_beat[p]);
            end
            if (axis_c2h_tvalid[p] && axis_c2h_tready[p]) begin
                if (c2h_q[p].size() == 0) begin
                    $display("Beat on c2h port %0d with no ingress beat pending for it", p);
                    other_errs++;
                end else begin
                    check_beat($sformatf("axis_c2h_beat[%0d]", p), c2h_q[p].pop_front(),
                               axis_c2h_beat[p]);
                end
            end
            if (axis_app_egr_tvalid[p] && axis_app_egr_tready[p]) begin
                src = axis_app_egr_beat[p].pid[15];
                if (egr_in_pkt[p] && src != egr_src[p]) begin
                    $display("Egress port %0d interleaved two packets", p);
                    other_errs++;
                end
                egr_src[p]    = src;
                egr_in_pkt[p] = !axis_app_egr_beat[p].tlast;
                if (egr_q[p][src].size() == 0) begin
                    $display("Beat on egress port %0d with no packet pending for it", p);
                    other_errs++;
                end else begin
                    check_beat($sformatf("axis_app_egr_beat[%0d]", p), egr_q[p][src].pop_front(),
                               axis_app_egr_beat[p]);
                end
            end
        end
        rvalid_seen = reg_rvalid;
        rdata_seen  = reg_rdata;
    endtask

    task automatic tick();
        @(negedge core_clk);
        monitor();
        @(posedge core_clk);
        #1;
    endtask

    function automatic logic all_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int s = 0; s < 2; s++) begin
                if (pkts_sent[s][p] != PKTS || beats_left[s][p] != 0 ||
                    egr_q[p][s].size() != 0) begin
                    return 1'b0;
                end
            end
            if (axis_app_igr_tvalid[p] || axis_h2c_tvalid[p] || c2h_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Sends PKTS packets from every source, then drains the DUT
    task automatic run_phase();
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkts_sent[0][p] = 0;
            pkts_sent[1][p] = 0;
        end
        do begin
            drive_inputs();
            tick();
        end while (!all_idle());
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        tick();
        reg_wr = 1'b0;
    endtask

    task automatic reg_check(input reg_addr_t addr, input logic [31:0] exp);
        reg_rd   = 1'b1;
        reg_addr = addr;
        tick();
        reg_rd = 1'b0;
        tick();
        check_flag("reg_rvalid", 1'b1, rvalid_seen);
        check_reg("reg_rdata", exp, rdata_seen);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rng_state           = 32'hfef94a58;
        rst                 = 1'b1;
        axis_app_igr_tvalid = '0;
        axis_h2c_tvalid     = '0;
        axis_c2h_tready     = '0;
        axis_app_egr_tready = '0;
        reg_wr              = 1'b0;
        reg_rd              = 1'b0;
        reg_addr            = REG_DEMUX_CTRL;
        reg_wdata           = '0;
        ovr                 = '0;
        rvalid_seen         = 1'b0;
        rdata_seen          = '0;
        val_errs            = 0;
        other_errs          = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            axis_app_igr_beat[p] = '0;
            axis_h2c_beat[p]     = '0;
            igr_in_pkt[p]        = 1'b0;
            egr_in_pkt[p]        = 1'b0;
            igr_done[p]          = 1'b0;
            h2c_done[p]          = 1'b0;
            for (int s = 0; s < 2; s++) begin
                beats_left[s][p] = 0;
                seq[s][p]        = 0;
            end
        end
        repeat (5) @(posedge core_clk);
        #1;
        rst = 1'b0;

        @(negedge core_clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_flag($sformatf("axis_c2h_tvalid[%0d]", p), 1'b0, axis_c2h_tvalid[p]);
            check_flag($sformatf("axis_app_egr_tvalid[%0d]", p), 1'b0, axis_app_egr_tvalid[p]);
        end
        check_flag("reg_rvalid", 1'b0, reg_rvalid);
        @(posedge core_clk);
        #1;
        reg_check(REG_DEMUX_CTRL, 32'h0);
        reg_check(reg_addr_t'(8'h10), REG_BAD_DATA);

        // Steering by tdest bit 0
        run_phase();
        reg_check(REG_STATUS, 32'h0);

        // Override, every ingress packet to c2h
        reg_write(REG_DEMUX_CTRL, 32'h3);
        ovr = demux_ctrl_t'(2'b11);
        reg_check(REG_DEMUX_CTRL, 32'h3);
        run_phase();

        // Override, every ingress packet looped back
        reg_write(REG_DEMUX_CTRL, 32'h1);
        ovr = demux_ctrl_t'(2'b01);
        reg_check(REG_DEMUX_CTRL, 32'h1);
        run_phase();
        reg_check(REG_STATUS, 32'h0);
        reg_check(reg_addr_t'(8'h08), REG_BAD_DATA);

        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule : tb_smartnic_app

/* build.f */
smartnic_pkg.sv
app_regs.sv
axis_demux.sv
axis_pipe.sv
axis_mux.sv
smartnic_app.sv
tb_smartnic_app_chk.sv
tb_smartnic_app.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_smartnic_app -f build.f

run: compile
	./obj_dir/Vtb_smartnic_app | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
